// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = tb_ooo_backend
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_checker.sv
`timescale 1ns/1ns

module tb_checker (
  input logic              in_clk,
  input logic              in_rst_n,
  input logic              commit_valid,
  input isa_pkg::gpr_idx_t commit_gpr,
  input isa_pkg::word_t    commit_value,
  input logic              commit_sets_nzcv,
  input isa_pkg::nzcv_t    commit_nzcv
);

  // Expected commits, oldest first
  isa_pkg::gpr_idx_t exp_gpr   [$];
  isa_pkg::word_t    exp_value [$];
  logic              exp_sets  [$];
  isa_pkg::nzcv_t    exp_nzcv  [$];

  string test_name = "none";
  int    test_commits = 0;
  int    test_errors = 0;
  int    total_commits = 0;
  int    total_errors = 0;
  int    tests_passed = 0;
  int    tests_failed = 0;

  task automatic start_test(input string name);
    test_name    = name;
    test_commits = 0;
    test_errors  = 0;
  endtask

  task automatic push_expected(input isa_pkg::gpr_idx_t gpr, input isa_pkg::word_t value,
                               input logic sets, input isa_pkg::nzcv_t nzcv);
    exp_gpr.push_back(gpr);
    exp_value.push_back(value);
    exp_sets.push_back(sets);
    exp_nzcv.push_back(nzcv);
  endtask

  function automatic int pending();
    return exp_gpr.size();
  endfunction

  task automatic report_error(input string what);
    $display("Error in test %s: %s", test_name, what);
    test_errors++;
  endtask

  task automatic check_field(input string field, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: %s expected %h actual %h", test_name, field, expected, actual);
      test_errors++;
    end
  endtask

  // Commit outputs change on the rising edge and are sampled mid-cycle
  always @(negedge in_clk) begin
    if (in_rst_n && commit_valid) begin
      if (exp_gpr.size() == 0) begin
        report_error($sformatf("commit to r%0d with no instruction outstanding", commit_gpr));
      end else begin
        check_field("commit_gpr", 32'(exp_gpr[0]), 32'(commit_gpr));
        check_field("commit_value", exp_value[0], commit_value);
        check_field("commit_sets_nzcv", 32'(exp_sets[0]), 32'(commit_sets_nzcv));
        if (exp_sets[0])
          check_field("commit_nzcv", 32'(exp_nzcv[0]), 32'(commit_nzcv));
        void'(exp_gpr.pop_front());
        void'(exp_value.pop_front());
        void'(exp_sets.pop_front());
        void'(exp_nzcv.pop_front());
      end
      test_commits++;
    end
  end

  task automatic finish_test();
    if (test_errors == 0) begin
      tests_passed++;
      $display("Test %s: ok, %0d commits", test_name, test_commits);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors in %0d commits", test_name, test_errors, test_commits);
    end
    total_commits += test_commits;
    total_errors  += test_errors;
  endtask

  task automatic print_totals();
    $display("Tests passed %0d, failed %0d, commits checked %0d, errors %0d",
             tests_passed, tests_failed, total_commits, total_errors);
  endtask

endmodule

// File: bench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 2,
  parameter int RESET_CYCLES = 5
) (
  output logic in_clk,
  output logic in_rst_n
);

  initial begin
    in_clk = 1'b0;
    forever #HALF_PERIOD in_clk = ~in_clk;
  end

  initial begin
    in_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge in_clk);
    @(negedge in_clk);
    in_rst_n = 1'b1;  // Released away from the active edge
  end

endmodule

// File: bench/tb_ooo_backend.sv
`timescale 1ns/1ns

module tb_ooo_backend;

  localparam int ROB_IDX_SIZE   = 2;
  localparam int MUL_CYCLES     = 3;
  localparam int READY_TIMEOUT  = 100;
  localparam int COMMIT_TIMEOUT = 200;
  localparam int RESET_TIMEOUT  = 20;
  localparam int RANDOM_COUNT   = 40;
  localparam int NUM_TESTS      = 6;
  localparam int NUM_STEPS      = 24;

  typedef struct packed {
    logic [2:0]        test;
    isa_pkg::alu_op_t  op;
    isa_pkg::gpr_idx_t dst;
    isa_pkg::gpr_idx_t src1;
    isa_pkg::gpr_idx_t src2;
    isa_pkg::imm_t     imm;
  } step_t;

  logic              in_clk, in_rst_n;
  logic              dispatch_valid, dispatch_ready;
  isa_pkg::alu_op_t  dispatch_op;
  isa_pkg::gpr_idx_t dispatch_dst, dispatch_src1, dispatch_src2;
  isa_pkg::imm_t     dispatch_imm;
  logic              commit_valid, commit_sets_nzcv;
  isa_pkg::gpr_idx_t commit_gpr;
  isa_pkg::word_t    commit_value;
  isa_pkg::nzcv_t    commit_nzcv;

  // In-order reference state
  isa_pkg::word_t model_regs [ooo_pkg::NUM_GPR];
  isa_pkg::nzcv_t model_flags;
  step_t          prog [$];
  logic           timed_out;
  integer         seed;

  string names [NUM_TESTS] = '{"reset_movi", "independent_alu", "dependent_chain",
                               "mul_in_order", "flags_adc", "random_40"};

  // Test id, op, dst, src1, src2, imm
  step_t steps [NUM_STEPS] = '{
    '{3'd1, isa_pkg::ADD,  4'd1,  4'd2,  4'd3,  16'h0000},
    '{3'd1, isa_pkg::SUB,  4'd4,  4'd5,  4'd6,  16'h0000},
    '{3'd1, isa_pkg::AND,  4'd7,  4'd8,  4'd9,  16'h0000},
    '{3'd1, isa_pkg::ORR,  4'd10, 4'd11, 4'd12, 16'h0000},
    '{3'd1, isa_pkg::EOR,  4'd13, 4'd14, 4'd15, 16'h0000},
    '{3'd2, isa_pkg::ADD,  4'd1,  4'd1,  4'd2,  16'h0000},
    '{3'd2, isa_pkg::ADD,  4'd3,  4'd1,  4'd1,  16'h0000},
    '{3'd2, isa_pkg::SUB,  4'd4,  4'd3,  4'd1,  16'h0000},
    '{3'd2, isa_pkg::EOR,  4'd1,  4'd4,  4'd3,  16'h0000},
    '{3'd2, isa_pkg::ADD,  4'd5,  4'd1,  4'd4,  16'h0000},
    '{3'd3, isa_pkg::MUL,  4'd6,  4'd2,  4'd3,  16'h0000},
    '{3'd3, isa_pkg::ADD,  4'd7,  4'd8,  4'd9,  16'h0000},
    '{3'd3, isa_pkg::ADD,  4'd10, 4'd11, 4'd12, 16'h0000},
    '{3'd3, isa_pkg::MUL,  4'd2,  4'd6,  4'd6,  16'h0000},
    '{3'd3, isa_pkg::ADD,  4'd8,  4'd2,  4'd7,  16'h0000},
    '{3'd4, isa_pkg::MOVI, 4'd1,  4'd0,  4'd0,  16'hffff},
    '{3'd4, isa_pkg::MOVI, 4'd2,  4'd0,  4'd0,  16'h0001},
    '{3'd4, isa_pkg::SUBS, 4'd3,  4'd1,  4'd2,  16'h0000},
    '{3'd4, isa_pkg::ADC,  4'd4,  4'd1,  4'd2,  16'h0000},
    '{3'd4, isa_pkg::SUBS, 4'd5,  4'd2,  4'd1,  16'h0000},
    '{3'd4, isa_pkg::ADC,  4'd6,  4'd5,  4'd1,  16'h0000},
    '{3'd4, isa_pkg::ADDS, 4'd7,  4'd5,  4'd5,  16'h0000},
    '{3'd4, isa_pkg::ADC,  4'd8,  4'd7,  4'd2,  16'h0000},
    '{3'd4, isa_pkg::SUBS, 4'd9,  4'd2,  4'd2,  16'h0000}
  };

  tb_clock_gen i_clock_gen (
    .in_clk,
    .in_rst_n
  );

  ooo_backend #(
    .ROB_IDX_SIZE(ROB_IDX_SIZE),
    .MUL_CYCLES  (MUL_CYCLES)
  ) i_ooo_backend (.*);

  tb_checker i_checker (.*);

  // Reference result with NZCV taken from the result and the carry out
  task automatic model_step(input step_t s, output isa_pkg::word_t value,
                            output logic sets, output isa_pkg::nzcv_t nzcv);
    isa_pkg::word_t a, b;
    logic [32:0]    wide;
    logic           carry, ovf;
    a     = model_regs[s.src1];
    b     = model_regs[s.src2];
    value = '0;
    wide  = '0;
    nzcv  = '0;
    sets  = 1'b0;
    case (s.op)
      isa_pkg::MOVI: value = {16'h0000, s.imm};
      isa_pkg::ADD:  value = a + b;
      isa_pkg::SUB:  value = a - b;
      isa_pkg::AND:  value = a & b;
      isa_pkg::ORR:  value = a | b;
      isa_pkg::EOR:  value = a ^ b;
      isa_pkg::MUL:  value = a * b;
      isa_pkg::ADDS: wide = {1'b0, a} + {1'b0, b};
      isa_pkg::SUBS: wide = {1'b0, a} - {1'b0, b};
      isa_pkg::ADC:  wide = {1'b0, a} + {1'b0, b} + {32'h0, model_flags[isa_pkg::FLAG_C]};
      default:       value = '0;
    endcase
    if (s.op inside {isa_pkg::ADDS, isa_pkg::SUBS, isa_pkg::ADC}) begin
      sets  = 1'b1;
      value = wide[31:0];
      carry = (s.op == isa_pkg::SUBS) ? (a >= b) : wide[32];  // Carry means no borrow
      ovf   = (s.op == isa_pkg::SUBS) ? (a[31] != b[31]) : (a[31] == b[31]);
      ovf   = ovf && (value[31] != a[31]);
      nzcv  = {value[31], value == 32'h0, carry, ovf};
      model_flags = nzcv;
    end
    model_regs[s.dst] = value;
  endtask

  function automatic step_t movi_step(input int r);
    step_t s;
    s.test = 3'd0;
    s.op   = isa_pkg::MOVI;
    s.dst  = isa_pkg::gpr_idx_t'(r);
    s.src1 = '0;
    s.src2 = '0;
    s.imm  = isa_pkg::imm_t'((r + 1) * 4661);
    return s;
  endfunction

  function automatic step_t random_step();
    step_t       s;
    logic [31:0] r;
    r      = $random(seed);
    s.test = 3'd5;
    s.op   = isa_pkg::alu_op_t'(4'(r % 32'd10));
    r      = $random(seed);
    s.dst  = r[3:0];
    s.src1 = r[7:4];
    s.src2 = r[11:8];
    s.imm  = r[31:16];
    return s;
  endfunction

  // Reset is released on a falling edge, so it is polled on the rising edge
  task automatic wait_reset();
    int n;
    n = 0;
    @(posedge in_clk);
    while (!in_rst_n && n < RESET_TIMEOUT) begin
      @(posedge in_clk);
      n++;
    end
    if (!in_rst_n) begin
      i_checker.report_error("reset never released");
      timed_out = 1'b1;
    end
    @(negedge in_clk);
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!dispatch_ready && n < READY_TIMEOUT) begin
      @(negedge in_clk);
      n++;
    end
    if (!dispatch_ready) begin
      i_checker.report_error("dispatch_ready stayed low, the back end stopped accepting");
      timed_out = 1'b1;
    end
  endtask

  task automatic dispatch_one(input step_t s);
    isa_pkg::word_t value;
    logic           sets;
    isa_pkg::nzcv_t nzcv;
    wait_ready();
    if (!timed_out) begin
      model_step(s, value, sets, nzcv);
      i_checker.push_expected(s.dst, value, sets, nzcv);
      dispatch_valid = 1'b1;
      dispatch_op    = s.op;
      dispatch_dst   = s.dst;
      dispatch_src1  = s.src1;
      dispatch_src2  = s.src2;
      dispatch_imm   = s.imm;
      @(negedge in_clk);
      dispatch_valid = 1'b0;
      if (dispatch_ready)
        i_checker.report_error("dispatch_ready high while the ALU station holds an instruction");
    end
  endtask

  task automatic wait_commits();
    int n;
    n = 0;
    while (i_checker.pending() != 0 && n < COMMIT_TIMEOUT) begin
      @(posedge in_clk);  // Checker pops on the falling edge
      n++;
    end
    if (i_checker.pending() != 0) begin
      i_checker.report_error($sformatf("%0d expected commits never arrived",
                                       i_checker.pending()));
      timed_out = 1'b1;
    end
    @(negedge in_clk);
  endtask

  initial begin
    dispatch_valid = 1'b0;
    dispatch_op    = isa_pkg::MOVI;
    dispatch_dst   = '0;
    dispatch_src1  = '0;
    dispatch_src2  = '0;
    dispatch_imm   = '0;
    timed_out      = 1'b0;
    seed           = 32'h65911a8e;
    model_flags    = '0;
    for (int r = 0; r < ooo_pkg::NUM_GPR; r++)
      model_regs[r] = '0;

    wait_reset();
    for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
      i_checker.start_test(names[t]);
      if (t == 0) begin
        if (!dispatch_ready || commit_valid)
          i_checker.report_error("dispatch_ready low or commit_valid high after reset");
        for (int r = 0; r < ooo_pkg::NUM_GPR; r++)
          prog.push_back(movi_step(r));
      end else if (t == 5) begin
        repeat (RANDOM_COUNT) prog.push_back(random_step());
      end else begin
        for (int i = 0; i < NUM_STEPS; i++) begin
          if (steps[i].test == 3'(t))
            prog.push_back(steps[i]);
        end
      end
      for (int i = 0; i < prog.size() && !timed_out; i++)
        dispatch_one(prog[i]);
      if (!timed_out)
        wait_commits();
      prog.delete();
      i_checker.finish_test();
    end

    i_checker.print_totals();
    if (!timed_out && i_checker.total_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: bench/tb_ooo_backend_assertions.sv
`timescale 1ns/1ns

module rob_assertions #(
  parameter int ROB_IDX_SIZE = 2
) (
  input logic                    in_clk,
  input logic                    in_rst_n,
  input logic [ROB_IDX_SIZE:0]   count_q,
  input logic [ROB_IDX_SIZE-1:0] head_q,
  input logic                    commit_valid,
  input logic                    fu_done,
  input logic [ROB_IDX_SIZE-1:0] fu_tag
);

  localparam int DEPTH = 2 ** ROB_IDX_SIZE;

  logic [ROB_IDX_SIZE-1:0] fu_offset;

  assign fu_offset = fu_tag - head_q;  // Distance from the oldest entry

  occupancy_bound: assert property (@(posedge in_clk) disable iff (!in_rst_n)
    int'(count_q) <= DEPTH)
    else $error("reorder buffer occupancy %0d above %0d entries", count_q, DEPTH);

  no_commit_in_reset: assert property (@(posedge in_clk) !in_rst_n |-> !commit_valid)
    else $error("commit_valid high during reset");

  fu_tag_allocated: assert property (@(posedge in_clk) disable iff (!in_rst_n)
    fu_done |-> ({1'b0, fu_offset} < count_q))
    else $error("fu_done for tag %0d outside the allocated entries", fu_tag);

endmodule

bind reorder_buffer rob_assertions #(.ROB_IDX_SIZE(ROB_IDX_SIZE)) i_rob_assertions (
  .in_clk,
  .in_rst_n,
  .count_q,
  .head_q,
  .commit_valid,
  .fu_done,
  .fu_tag
);

// File: src.f
src/isa_pkg.sv
src/ooo_pkg.sv
src/rename_stage.sv
src/reorder_buffer.sv
src/alu_station.sv
src/ooo_backend.sv
bench/tb_clock_gen.sv
bench/tb_checker.sv
bench/tb_ooo_backend_assertions.sv
bench/tb_ooo_backend.sv

// File: src/alu_station.sv
`timescale 1ns/1ns

module alu_station #(
  parameter int ROB_IDX_SIZE = 2,
  parameter int MUL_CYCLES   = 3
) (
  input  logic                    in_clk,
  input  logic                    in_rst_n,
  input  logic                    issue_valid,
  input  isa_pkg::alu_op_t        issue_op,
  input  isa_pkg::imm_t           issue_imm,
  input  logic [ROB_IDX_SIZE-1:0] issue_dst_tag,
  input  logic                    issue_src1_ready,
  input  isa_pkg::word_t          issue_src1_value,
  input  logic [ROB_IDX_SIZE-1:0] issue_src1_tag,
  input  logic                    issue_src2_ready,
  input  isa_pkg::word_t          issue_src2_value,
  input  logic [ROB_IDX_SIZE-1:0] issue_src2_tag,
  input  logic                    issue_nzcv_ready,
  input  isa_pkg::nzcv_t          issue_nzcv_value,
  input  logic [ROB_IDX_SIZE-1:0] issue_nzcv_tag,
  input  logic                    bc_valid,
  input  logic [ROB_IDX_SIZE-1:0] bc_tag,
  input  isa_pkg::word_t          bc_value,
  input  isa_pkg::nzcv_t          bc_nzcv,
  output logic                    station_busy,
  output logic                    fu_done,
  output logic [ROB_IDX_SIZE-1:0] fu_tag,
  output isa_pkg::word_t          fu_value,
  output logic                    fu_sets_nzcv,
  output isa_pkg::nzcv_t          fu_nzcv
);

  localparam int CNT_W = $clog2(MUL_CYCLES + 1);

  typedef logic [ROB_IDX_SIZE-1:0] tag_t;

  ooo_pkg::alu_state_t state_q;
  logic [CNT_W-1:0]    cnt_q;
  isa_pkg::alu_op_t    op_q;
  isa_pkg::imm_t       imm_q;
  tag_t                dst_q, a_tag_q, b_tag_q, f_tag_q;
  logic                a_rdy_q, b_rdy_q, f_rdy_q;
  isa_pkg::word_t      a_q, b_q;
  isa_pkg::nzcv_t      f_q;
  logic                a_ok, b_ok, f_ok, last;

  // ALU datapath
  isa_pkg::word_t opb, result;
  logic           cin;
  logic [32:0]    sum;
  isa_pkg::nzcv_t flags;

  assign station_busy = issue_valid || (state_q != ooo_pkg::IDLE);

  // Ready now or matched on the broadcast
  assign a_ok = a_rdy_q || (bc_valid && bc_tag == a_tag_q);
  assign b_ok = b_rdy_q || (bc_valid && bc_tag == b_tag_q);
  assign f_ok = f_rdy_q || (bc_valid && bc_tag == f_tag_q);
  assign last = (op_q != isa_pkg::MUL) || (cnt_q == CNT_W'(MUL_CYCLES - 1));

  always_comb begin
    opb = b_q;
    cin = 1'b0;
    if (op_q inside {isa_pkg::SUB, isa_pkg::SUBS}) begin
      opb = ~b_q;  // a + ~b + 1 so carry set means no borrow
      cin = 1'b1;
    end else if (op_q == isa_pkg::ADC) begin
      cin = f_q[isa_pkg::FLAG_C];
    end
    sum = {1'b0, a_q} + {1'b0, opb} + 33'(cin);
    case (op_q)
      isa_pkg::MOVI: result = isa_pkg::word_t'(imm_q);
      isa_pkg::AND:  result = a_q & b_q;
      isa_pkg::ORR:  result = a_q | b_q;
      isa_pkg::EOR:  result = a_q ^ b_q;
      isa_pkg::MUL:  result = a_q * b_q;  // Low word only
      default:       result = sum[31:0];
    endcase
    flags[isa_pkg::FLAG_N] = result[31];
    flags[isa_pkg::FLAG_Z] = result == '0;
    flags[isa_pkg::FLAG_C] = sum[32];
    flags[isa_pkg::FLAG_V] = (a_q[31] == opb[31]) && (result[31] != a_q[31]);
  end

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      state_q <= ooo_pkg::IDLE;
      cnt_q   <= '0;
      fu_done <= 1'b0;
      a_rdy_q <= 1'b0;
      b_rdy_q <= 1'b0;
      f_rdy_q <= 1'b0;
    end else begin
      fu_done <= 1'b0;
      case (state_q)
        ooo_pkg::IDLE: if (issue_valid) begin
          a_rdy_q <= issue_src1_ready;
          b_rdy_q <= issue_src2_ready;
          f_rdy_q <= issue_nzcv_ready;
          state_q <= (issue_src1_ready && issue_src2_ready && issue_nzcv_ready) ?
                     ooo_pkg::EXEC : ooo_pkg::WAIT_OPS;
        end
        ooo_pkg::WAIT_OPS: begin
          a_rdy_q <= a_ok;
          b_rdy_q <= b_ok;
          f_rdy_q <= f_ok;
          if (a_ok && b_ok && f_ok)
            state_q <= ooo_pkg::EXEC;
        end
        ooo_pkg::EXEC: if (last) begin
          fu_done <= 1'b1;
          cnt_q   <= '0;
          state_q <= ooo_pkg::IDLE;
        end else begin
          cnt_q <= cnt_q + 1'b1;  // MUL still busy
        end
        default: state_q <= ooo_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge in_clk) begin
    if (state_q == ooo_pkg::IDLE && issue_valid) begin
      op_q    <= issue_op;
      imm_q   <= issue_imm;
      dst_q   <= issue_dst_tag;
      a_q     <= issue_src1_value;
      a_tag_q <= issue_src1_tag;
      b_q     <= issue_src2_value;
      b_tag_q <= issue_src2_tag;
      f_q     <= issue_nzcv_value;
      f_tag_q <= issue_nzcv_tag;
    end
    if (state_q == ooo_pkg::WAIT_OPS) begin
      if (!a_rdy_q && a_ok)
        a_q <= bc_value;
      if (!b_rdy_q && b_ok)
        b_q <= bc_value;
      if (!f_rdy_q && f_ok)
        f_q <= bc_nzcv;
    end
    if (state_q == ooo_pkg::EXEC && last) begin
      fu_tag       <= dst_q;
      fu_value     <= result;
      fu_sets_nzcv <= isa_pkg::sets_nzcv(op_q);
      fu_nzcv      <= flags;
    end
  end

endmodule

// File: src/isa_pkg.sv
package isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  gpr_idx_t;  // 16 GPRs
  typedef logic [3:0]  nzcv_t;     // N Z C V with N in bit 3
  typedef logic [15:0] imm_t;      // Zero extended

  localparam int FLAG_N = 3;
  localparam int FLAG_Z = 2;
  localparam int FLAG_C = 1;
  localparam int FLAG_V = 0;

  typedef enum logic [3:0] {
    MOVI,
    ADD,
    ADDS,
    SUB,
    SUBS,
    ADC,
    AND,
    ORR,
    EOR,
    MUL
  } alu_op_t;

  // Ops that write NZCV
  function automatic logic sets_nzcv(alu_op_t op);
    return op inside {ADDS, SUBS, ADC};
  endfunction

  // Only ADC consumes the carry
  function automatic logic reads_nzcv(alu_op_t op);
    return op == ADC;
  endfunction

endpackage

// File: src/ooo_backend.sv
`timescale 1ns/1ns

module ooo_backend #(
  parameter int ROB_IDX_SIZE = 2,
  parameter int MUL_CYCLES   = 3
) (
  input  logic              in_clk,
  input  logic              in_rst_n,
  input  logic              dispatch_valid,
  input  isa_pkg::alu_op_t  dispatch_op,
  input  isa_pkg::gpr_idx_t dispatch_dst,
  input  isa_pkg::gpr_idx_t dispatch_src1,
  input  isa_pkg::gpr_idx_t dispatch_src2,
  input  isa_pkg::imm_t     dispatch_imm,
  output logic              dispatch_ready,
  output logic              commit_valid,
  output isa_pkg::gpr_idx_t commit_gpr,
  output isa_pkg::word_t    commit_value,
  output logic              commit_sets_nzcv,
  output isa_pkg::nzcv_t    commit_nzcv
);

  typedef logic [ROB_IDX_SIZE-1:0] tag_t;

  // Rename to reorder buffer
  logic              alloc_valid, alloc_sets_nzcv, rob_full, station_busy;
  isa_pkg::gpr_idx_t alloc_dst;
  isa_pkg::alu_op_t  alloc_op;
  isa_pkg::imm_t     alloc_imm;
  logic              src1_ready, src2_ready, nzcv_ready;
  isa_pkg::word_t    src1_value, src2_value;
  isa_pkg::nzcv_t    nzcv_value;
  tag_t              src1_tag, src2_tag, nzcv_tag, next_tag, commit_tag;

  // Reorder buffer to station
  logic              issue_valid, issue_src1_ready, issue_src2_ready, issue_nzcv_ready;
  isa_pkg::alu_op_t  issue_op;
  isa_pkg::imm_t     issue_imm;
  isa_pkg::word_t    issue_src1_value, issue_src2_value;
  isa_pkg::nzcv_t    issue_nzcv_value;
  tag_t              issue_dst_tag, issue_src1_tag, issue_src2_tag, issue_nzcv_tag;

  // Results and broadcast
  logic              fu_done, fu_sets_nzcv, bc_valid;
  tag_t              fu_tag, bc_tag;
  isa_pkg::word_t    fu_value, bc_value;
  isa_pkg::nzcv_t    fu_nzcv, bc_nzcv;

  rename_stage #(.ROB_IDX_SIZE(ROB_IDX_SIZE)) i_rename_stage (.*);

  reorder_buffer #(.ROB_IDX_SIZE(ROB_IDX_SIZE)) i_reorder_buffer (.*);

  alu_station #(
    .ROB_IDX_SIZE(ROB_IDX_SIZE),
    .MUL_CYCLES  (MUL_CYCLES)
  ) i_alu_station (.*);

endmodule

// File: src/ooo_pkg.sv
package ooo_pkg;

  localparam int NUM_GPR = 16;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_OPS,
    EXEC
  } alu_state_t;

  // Where a dispatched operand is taken from
  typedef enum logic [1:0] {
    SEL_ARCH,    // Committed register or flags
    SEL_BYPASS,  // Commit landing this cycle
    SEL_TAG      // Still in flight
  } src_sel_t;

endpackage

// File: src/rename_stage.sv
`timescale 1ns/1ns

module rename_stage #(
  parameter int ROB_IDX_SIZE = 2
) (
  input  logic                    in_clk,
  input  logic                    in_rst_n,
  input  logic                    dispatch_valid,
  input  isa_pkg::alu_op_t        dispatch_op,
  input  isa_pkg::gpr_idx_t       dispatch_dst,
  input  isa_pkg::gpr_idx_t       dispatch_src1,
  input  isa_pkg::gpr_idx_t       dispatch_src2,
  input  isa_pkg::imm_t           dispatch_imm,
  output logic                    dispatch_ready,
  input  logic                    rob_full,
  input  logic                    station_busy,
  input  logic [ROB_IDX_SIZE-1:0] next_tag,
  output logic                    alloc_valid,
  output isa_pkg::gpr_idx_t       alloc_dst,
  output logic                    alloc_sets_nzcv,
  output isa_pkg::alu_op_t        alloc_op,
  output isa_pkg::imm_t           alloc_imm,
  output logic                    src1_ready,
  output isa_pkg::word_t          src1_value,
  output logic [ROB_IDX_SIZE-1:0] src1_tag,
  output logic                    src2_ready,
  output isa_pkg::word_t          src2_value,
  output logic [ROB_IDX_SIZE-1:0] src2_tag,
  output logic                    nzcv_ready,
  output isa_pkg::nzcv_t          nzcv_value,
  output logic [ROB_IDX_SIZE-1:0] nzcv_tag,
  input  logic                    commit_valid,
  input  logic [ROB_IDX_SIZE-1:0] commit_tag,
  input  isa_pkg::gpr_idx_t       commit_gpr,
  input  isa_pkg::word_t          commit_value,
  input  logic                    commit_sets_nzcv,
  input  isa_pkg::nzcv_t          commit_nzcv
);

  typedef logic [ROB_IDX_SIZE-1:0] tag_t;

  isa_pkg::word_t    arch_q [ooo_pkg::NUM_GPR];
  logic              busy_q [ooo_pkg::NUM_GPR];
  tag_t              tag_q  [ooo_pkg::NUM_GPR];
  isa_pkg::nzcv_t    flags_q;
  logic              flags_busy_q;
  tag_t              flags_tag_q;
  ooo_pkg::src_sel_t sel1, sel2, sel_f;
  logic              uses_regs;

  function automatic ooo_pkg::src_sel_t pick_src(logic used, logic busy, tag_t tag,
                                                 logic cvalid, tag_t ctag);
    if (!used || !busy)
      return ooo_pkg::SEL_ARCH;
    else if (cvalid && ctag == tag)
      return ooo_pkg::SEL_BYPASS;  // Producer commits on this edge
    return ooo_pkg::SEL_TAG;
  endfunction

  assign dispatch_ready  = !rob_full && !station_busy;
  assign alloc_valid     = dispatch_valid && dispatch_ready;
  assign alloc_dst       = dispatch_dst;
  assign alloc_sets_nzcv = isa_pkg::sets_nzcv(dispatch_op);
  assign alloc_op        = dispatch_op;
  assign alloc_imm       = dispatch_imm;
  assign uses_regs       = dispatch_op != isa_pkg::MOVI;

  assign sel1 = pick_src(uses_regs, busy_q[dispatch_src1], tag_q[dispatch_src1],
                         commit_valid, commit_tag);
  assign sel2 = pick_src(uses_regs, busy_q[dispatch_src2], tag_q[dispatch_src2],
                         commit_valid, commit_tag);
  assign sel_f = pick_src(isa_pkg::reads_nzcv(dispatch_op), flags_busy_q, flags_tag_q,
                          commit_valid, commit_tag);

  assign src1_ready = sel1 != ooo_pkg::SEL_TAG;
  assign src1_value = (sel1 == ooo_pkg::SEL_BYPASS) ? commit_value : arch_q[dispatch_src1];
  assign src1_tag   = tag_q[dispatch_src1];
  assign src2_ready = sel2 != ooo_pkg::SEL_TAG;
  assign src2_value = (sel2 == ooo_pkg::SEL_BYPASS) ? commit_value : arch_q[dispatch_src2];
  assign src2_tag   = tag_q[dispatch_src2];
  assign nzcv_ready = sel_f != ooo_pkg::SEL_TAG;
  assign nzcv_value = (sel_f == ooo_pkg::SEL_BYPASS) ? commit_nzcv : flags_q;
  assign nzcv_tag   = flags_tag_q;

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      for (int i = 0; i < ooo_pkg::NUM_GPR; i++) begin
        arch_q[i] <= '0;
        busy_q[i] <= 1'b0;
        tag_q[i]  <= '0;
      end
      flags_q      <= '0;
      flags_busy_q <= 1'b0;
      flags_tag_q  <= '0;
    end else begin
      if (commit_valid) begin
        arch_q[commit_gpr] <= commit_value;
        // A younger writer keeps the register busy
        if (tag_q[commit_gpr] == commit_tag)
          busy_q[commit_gpr] <= 1'b0;
        if (commit_sets_nzcv) begin
          flags_q <= commit_nzcv;
          if (flags_tag_q == commit_tag)
            flags_busy_q <= 1'b0;
        end
      end
      // Rename after commit so a new writer wins
      if (alloc_valid) begin
        busy_q[dispatch_dst] <= 1'b1;
        tag_q[dispatch_dst]  <= next_tag;
        if (alloc_sets_nzcv) begin
          flags_busy_q <= 1'b1;
          flags_tag_q  <= next_tag;
        end
      end
    end
  end

endmodule

// File: src/reorder_buffer.sv
`timescale 1ns/1ns

module reorder_buffer #(
  parameter int ROB_IDX_SIZE = 2
) (
  input  logic                    in_clk,
  input  logic                    in_rst_n,
  input  logic                    alloc_valid,
  input  isa_pkg::gpr_idx_t       alloc_dst,
  input  logic                    alloc_sets_nzcv,
  input  isa_pkg::alu_op_t        alloc_op,
  input  isa_pkg::imm_t           alloc_imm,
  input  logic                    src1_ready,
  input  isa_pkg::word_t          src1_value,
  input  logic [ROB_IDX_SIZE-1:0] src1_tag,
  input  logic                    src2_ready,
  input  isa_pkg::word_t          src2_value,
  input  logic [ROB_IDX_SIZE-1:0] src2_tag,
  input  logic                    nzcv_ready,
  input  isa_pkg::nzcv_t          nzcv_value,
  input  logic [ROB_IDX_SIZE-1:0] nzcv_tag,
  output logic [ROB_IDX_SIZE-1:0] next_tag,
  output logic                    rob_full,
  output logic                    issue_valid,
  output isa_pkg::alu_op_t        issue_op,
  output isa_pkg::imm_t           issue_imm,
  output logic [ROB_IDX_SIZE-1:0] issue_dst_tag,
  output logic                    issue_src1_ready,
  output isa_pkg::word_t          issue_src1_value,
  output logic [ROB_IDX_SIZE-1:0] issue_src1_tag,
  output logic                    issue_src2_ready,
  output isa_pkg::word_t          issue_src2_value,
  output logic [ROB_IDX_SIZE-1:0] issue_src2_tag,
  output logic                    issue_nzcv_ready,
  output isa_pkg::nzcv_t          issue_nzcv_value,
  output logic [ROB_IDX_SIZE-1:0] issue_nzcv_tag,
  input  logic                    fu_done,
  input  logic [ROB_IDX_SIZE-1:0] fu_tag,
  input  isa_pkg::word_t          fu_value,
  input  logic                    fu_sets_nzcv,
  input  isa_pkg::nzcv_t          fu_nzcv,
  output logic                    bc_valid,
  output logic [ROB_IDX_SIZE-1:0] bc_tag,
  output isa_pkg::word_t          bc_value,
  output isa_pkg::nzcv_t          bc_nzcv,
  output logic                    commit_valid,
  output logic [ROB_IDX_SIZE-1:0] commit_tag,
  output isa_pkg::gpr_idx_t       commit_gpr,
  output isa_pkg::word_t          commit_value,
  output logic                    commit_sets_nzcv,
  output isa_pkg::nzcv_t          commit_nzcv
);

  localparam int DEPTH = 2 ** ROB_IDX_SIZE;

  typedef logic [ROB_IDX_SIZE-1:0] tag_t;
  typedef logic [ROB_IDX_SIZE:0]   count_t;

  // Entry array
  logic              done_q  [DEPTH];
  isa_pkg::gpr_idx_t gpr_q   [DEPTH];
  isa_pkg::word_t    value_q [DEPTH];
  logic              sets_q  [DEPTH];
  isa_pkg::nzcv_t    nzcv_q  [DEPTH];
  tag_t              head_q, tail_q;
  count_t            count_q;

  // Allocation held for one cycle until issue
  logic s1_rdy_q, s2_rdy_q, f_rdy_q;
  isa_pkg::word_t s1_val_q, s2_val_q;
  isa_pkg::nzcv_t f_val_q;
  tag_t s1_tag_q, s2_tag_q, f_tag_q;

  assign next_tag = tail_q;
  assign rob_full = count_q == count_t'(DEPTH);

  // Operands finished since rename are forwarded from the entry
  assign issue_src1_ready = s1_rdy_q || done_q[s1_tag_q];
  assign issue_src1_value = s1_rdy_q ? s1_val_q : value_q[s1_tag_q];
  assign issue_src1_tag   = s1_tag_q;
  assign issue_src2_ready = s2_rdy_q || done_q[s2_tag_q];
  assign issue_src2_value = s2_rdy_q ? s2_val_q : value_q[s2_tag_q];
  assign issue_src2_tag   = s2_tag_q;
  assign issue_nzcv_ready = f_rdy_q || done_q[f_tag_q];
  assign issue_nzcv_value = f_rdy_q ? f_val_q : nzcv_q[f_tag_q];
  assign issue_nzcv_tag   = f_tag_q;

  assign bc_value = value_q[bc_tag];
  assign bc_nzcv  = nzcv_q[bc_tag];

  assign commit_valid     = (count_q != '0) && done_q[head_q];
  assign commit_tag       = head_q;
  assign commit_gpr       = gpr_q[head_q];
  assign commit_value     = value_q[head_q];
  assign commit_sets_nzcv = sets_q[head_q];
  assign commit_nzcv      = nzcv_q[head_q];

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      head_q      <= '0;
      tail_q      <= '0;
      count_q     <= '0;
      issue_valid <= 1'b0;
      bc_valid    <= 1'b0;
      for (int i = 0; i < DEPTH; i++)
        done_q[i] <= 1'b0;
    end else begin
      issue_valid <= alloc_valid;
      bc_valid    <= fu_done;
      if (alloc_valid) begin
        done_q[tail_q] <= 1'b0;
        tail_q         <= tail_q + 1'b1;  // Wraps with the tag width
      end
      if (fu_done)
        done_q[fu_tag] <= 1'b1;
      if (commit_valid)
        head_q <= head_q + 1'b1;
      count_q <= count_q + count_t'(alloc_valid) - count_t'(commit_valid);
    end
  end

  always_ff @(posedge in_clk) begin
    if (alloc_valid) begin
      gpr_q[tail_q]  <= alloc_dst;
      sets_q[tail_q] <= alloc_sets_nzcv;
    end
    if (fu_done) begin
      value_q[fu_tag] <= fu_value;
      nzcv_q[fu_tag]  <= fu_sets_nzcv ? fu_nzcv : '0;  // Zero for non-setting ops
    end
    bc_tag        <= fu_tag;
    issue_op      <= alloc_op;
    issue_imm     <= alloc_imm;
    issue_dst_tag <= tail_q;
    s1_rdy_q      <= src1_ready;
    s1_val_q      <= src1_value;
    s1_tag_q      <= src1_tag;
    s2_rdy_q      <= src2_ready;
    s2_val_q      <= src2_value;
    s2_tag_q      <= src2_tag;
    f_rdy_q       <= nzcv_ready;
    f_val_q       <= nzcv_value;
    f_tag_q       <= nzcv_tag;
  end

endmodule
